// File: Makefile
# Verilator simulation of the basics command block

VERILATOR ?= verilator
TOP ?= basics_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
EXTRA_FLAGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(EXTRA_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
hw/ice_cmd_pkg.sv
hw/ice_msg_pkg.sv
hw/byte_counter.sv
hw/param_bank.sv
hw/ack_builder.sv
hw/response_buffer.sv
hw/basics_fsm.sv
hw/basics_top.sv
test/tb_clock.sv
test/basics_asserts.sv
test/basics_tb.sv

// File: hw/ack_builder.sv
`timescale 1ns/100ps

module ack_builder (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic [7:0]              code,
	input  logic [7:0]              eid,
	input  logic [7:0]              length,
	output ice_msg_pkg::resp_byte_t hdr,
	output logic                    active
);

	logic [1:0] seq;
	logic [7:0] code_q;
	logic [7:0] eid_q;
	logic [7:0] len_q;

	// 0 idle, 1..3 select code, EID, length
	always_ff @(posedge clk) begin
		if (rst) begin
			seq <= 2'd0;
		end else if (start) begin
			seq <= 2'd1;
		end else if (seq != 2'd0) begin
			// Wraps back to idle after the length byte
			seq <= seq + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			code_q <= code;
			eid_q <= eid;
			len_q <= length;
		end
	end

	always_comb begin
		hdr.valid = (seq != 2'd0);
		case (seq)
			2'd1: hdr.data = code_q;
			2'd2: hdr.data = eid_q;
			default: hdr.data = len_q;
		endcase
	end

	assign active = (seq != 2'd0);

endmodule

// File: hw/basics_fsm.sv
`timescale 1ns/100ps

module basics_fsm (
	input  logic                    clk,
	input  logic                    rst,
	input  ice_msg_pkg::bus_in_t    bus,
	input  logic                    generate_nak,
	output logic                    ack_start,
	output logic [7:0]              ack_code,
	output logic [7:0]              ack_eid,
	output logic [7:0]              ack_length,
	input  ice_msg_pkg::resp_byte_t ack_hdr,
	input  logic                    ack_active,
	output ice_cmd_pkg::param_e     pb_target,
	output logic                    pb_stage,
	output logic                    pb_shift_in,
	output logic [7:0]              pb_in_byte,
	output logic                    pb_commit,
	output logic                    pb_snap,
	output logic                    pb_shift_out,
	input  logic [7:0]              pb_out_byte,
	output logic                    cnt_load,
	output logic [3:0]              cnt_load_value,
	output logic                    cnt_dec,
	input  logic                    cnt_zero,
	output ice_msg_pkg::resp_byte_t buf_wr,
	output logic                    frame_end,
	input  logic                    buf_busy
);

	typedef enum logic [3:0] {
		s_idle,
		s_eid,
		s_len,
		s_ver,
		s_ver_chk,
		s_sel,
		s_snap,
		s_set_data,
		s_commit,
		s_hdr,
		s_hdr_wait,
		s_data,
		s_end,
		s_wait
	} state_e;

	state_e state;
	state_e state_n;
	logic frame_q;
	logic frame_start;
	logic cmd_known;
	logic cmd_is_set;
	logic [7:0] cmd_q;
	logic [7:0] eid_q;
	logic [15:0] ver_q;
	logic [7:0] resp_code;
	logic [3:0] resp_len;
	logic resp_param;
	logic [7:0] data_byte;
	ice_cmd_pkg::param_e target_q;
	ice_cmd_pkg::param_e sel_target;

	// Value bytes per parameter
	function automatic logic [3:0] param_len(input ice_cmd_pkg::param_e p);
		case (p)
			ice_cmd_pkg::p_i2c_speed: return 4'd1;
			ice_cmd_pkg::p_i2c_addr, ice_cmd_pkg::p_uart_baud: return 4'd2;
			ice_cmd_pkg::p_gpio_level, ice_cmd_pkg::p_gpio_dir: return 4'd3;
			default: return 4'd0;
		endcase
	endfunction

	assign frame_start = bus.valid && bus.frame && !frame_q;

	always_comb begin
		case (bus.data)
			ice_cmd_pkg::cmd_version,
			ice_cmd_pkg::cmd_query_i2c, ice_cmd_pkg::cmd_set_i2c,
			ice_cmd_pkg::cmd_query_gpio, ice_cmd_pkg::cmd_set_gpio,
			ice_cmd_pkg::cmd_query_uart, ice_cmd_pkg::cmd_set_uart: cmd_known = 1'b1;
			default: cmd_known = 1'b0;
		endcase
	end

	assign cmd_is_set = (cmd_q == ice_cmd_pkg::cmd_set_i2c) ||
		(cmd_q == ice_cmd_pkg::cmd_set_gpio) || (cmd_q == ice_cmd_pkg::cmd_set_uart);

	// Selector decode against the latched command group
	always_comb begin
		sel_target = ice_cmd_pkg::p_none;
		case (cmd_q)
			ice_cmd_pkg::cmd_query_i2c, ice_cmd_pkg::cmd_set_i2c: begin
				if (bus.data == ice_cmd_pkg::sel_speed) begin
					sel_target = ice_cmd_pkg::p_i2c_speed;
				end else if (bus.data == ice_cmd_pkg::sel_addr) begin
					sel_target = ice_cmd_pkg::p_i2c_addr;
				end
			end
			ice_cmd_pkg::cmd_query_gpio, ice_cmd_pkg::cmd_set_gpio: begin
				if (bus.data == ice_cmd_pkg::sel_level) begin
					sel_target = ice_cmd_pkg::p_gpio_level;
				end else if (bus.data == ice_cmd_pkg::sel_dir) begin
					sel_target = ice_cmd_pkg::p_gpio_dir;
				end
			end
			ice_cmd_pkg::cmd_query_uart, ice_cmd_pkg::cmd_set_uart: begin
				sel_target = ice_cmd_pkg::p_uart_baud;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		state_n = state;
		ack_start = 1'b0;
		pb_stage = 1'b0;
		pb_shift_in = 1'b0;
		pb_commit = 1'b0;
		pb_snap = 1'b0;
		pb_shift_out = 1'b0;
		cnt_load = 1'b0;
		cnt_load_value = 4'd0;
		cnt_dec = 1'b0;
		frame_end = 1'b0;
		case (state)
			s_idle: begin
				if (generate_nak) begin
					state_n = s_hdr;
				end else if (frame_start && cmd_known) begin
					state_n = s_eid;
				end
			end
			s_eid: begin
				if (bus.valid) begin
					state_n = s_len;
				end else if (!bus.frame) begin
					state_n = s_idle;
				end
			end
			s_len: begin
				if (bus.valid) begin
					if (cmd_q == ice_cmd_pkg::cmd_version) begin
						cnt_load = 1'b1;
						cnt_load_value = 4'd1;
						state_n = s_ver;
					end else begin
						state_n = s_sel;
					end
				end else if (!bus.frame) begin
					state_n = s_idle;
				end
			end
			s_ver: begin
				if (bus.valid) begin
					cnt_dec = 1'b1;
					if (cnt_zero) begin
						state_n = s_ver_chk;
					end
				end else if (!bus.frame) begin
					state_n = s_idle;
				end
			end
			s_ver_chk: state_n = s_hdr;
			s_sel: begin
				if (bus.valid) begin
					if (sel_target == ice_cmd_pkg::p_none) begin
						state_n = s_hdr;
					end else if (cmd_is_set) begin
						pb_stage = 1'b1;
						cnt_load = 1'b1;
						cnt_load_value = param_len(sel_target) - 4'd1;
						state_n = s_set_data;
					end else begin
						state_n = s_snap;
					end
				end else if (!bus.frame) begin
					state_n = s_idle;
				end
			end
			s_snap: begin
				pb_snap = 1'b1;
				state_n = s_hdr;
			end
			s_set_data: begin
				if (bus.valid) begin
					pb_shift_in = 1'b1;
					cnt_dec = 1'b1;
					if (cnt_zero) begin
						state_n = s_commit;
					end
				end else if (!bus.frame) begin
					state_n = s_idle;
				end
			end
			s_commit: begin
				pb_commit = 1'b1;
				state_n = s_hdr;
			end
			s_hdr: begin
				ack_start = 1'b1;
				cnt_load = 1'b1;
				cnt_load_value = resp_len - 4'd1;
				state_n = s_hdr_wait;
			end
			s_hdr_wait: begin
				if (!ack_active) begin
					state_n = (resp_len == 4'd0) ? s_end : s_data;
				end
			end
			s_data: begin
				cnt_dec = 1'b1;
				pb_shift_out = resp_param;
				if (cnt_zero) begin
					state_n = s_end;
				end
			end
			s_end: begin
				frame_end = 1'b1;
				state_n = s_wait;
			end
			s_wait: begin
				if (!buf_busy) begin
					state_n = s_idle;
				end
			end
			default: state_n = s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			frame_q <= 1'b0;
		end else begin
			state <= state_n;
			frame_q <= bus.frame;
		end
	end

	// Response fields, settled before s_hdr
	always_ff @(posedge clk) begin
		case (state)
			s_idle: begin
				cmd_q <= bus.data;
				if (generate_nak) begin
					eid_q <= 8'h00;
					resp_code <= ice_msg_pkg::code_nak;
					resp_len <= 4'd0;
				end
			end
			s_eid: begin
				if (bus.valid) begin
					eid_q <= bus.data;
				end
			end
			s_ver: begin
				if (bus.valid) begin
					ver_q <= {ver_q[7:0], bus.data};
				end
			end
			s_ver_chk: begin
				resp_param <= 1'b0;
				if (ver_q == {ice_cmd_pkg::version_major, ice_cmd_pkg::version_minor}) begin
					resp_code <= ice_msg_pkg::code_ack;
					resp_len <= 4'd0;
				end else begin
					resp_code <= ice_msg_pkg::code_nak;
					resp_len <= 4'd2;
				end
			end
			s_sel: begin
				if (bus.valid) begin
					target_q <= sel_target;
					resp_param <= 1'b1;
					resp_code <= (sel_target == ice_cmd_pkg::p_none) ?
						ice_msg_pkg::code_nak : ice_msg_pkg::code_ack;
					resp_len <= cmd_is_set ? 4'd0 : param_len(sel_target);
				end
			end
			default: begin
			end
		endcase
	end

	// Version NAK sends major then minor, counter loaded with 1
	assign data_byte = resp_param ? pb_out_byte :
		(cnt_zero ? ice_cmd_pkg::version_minor : ice_cmd_pkg::version_major);

	// Header and data never overlap
	always_comb begin
		if (ack_hdr.valid) begin
			buf_wr = ack_hdr;
		end else begin
			buf_wr.data = data_byte;
			buf_wr.valid = (state == s_data);
		end
	end

	assign ack_code = resp_code;
	assign ack_eid = eid_q;
	assign ack_length = {4'h0, resp_len};
	assign pb_target = target_q;
	assign pb_in_byte = bus.data;

endmodule

// File: hw/basics_top.sv
`timescale 1ns/100ps

module basics_top (
	input  logic                    clk,
	input  logic                    rst,
	input  ice_msg_pkg::bus_in_t    bus,
	input  logic                    generate_nak,
	input  logic [23:0]             gpio_read,
	output ice_msg_pkg::resp_byte_t resp,
	output logic                    resp_frame_valid,
	output ice_cmd_pkg::settings_t  settings
);

	logic ack_start;
	logic [7:0] ack_code;
	logic [7:0] ack_eid;
	logic [7:0] ack_length;
	logic ack_active;
	ice_msg_pkg::resp_byte_t ack_hdr;
	ice_cmd_pkg::param_e pb_target;
	logic pb_stage;
	logic pb_shift_in;
	logic [7:0] pb_in_byte;
	logic pb_commit;
	logic pb_snap;
	logic pb_shift_out;
	logic [7:0] pb_out_byte;
	logic cnt_load;
	logic [3:0] cnt_load_value;
	logic cnt_dec;
	logic cnt_zero;
	ice_msg_pkg::resp_byte_t buf_wr;
	logic frame_end;
	logic buf_busy;

	basics_fsm u_fsm (
		.clk(clk), .rst(rst), .bus(bus), .generate_nak(generate_nak),
		.ack_start(ack_start), .ack_code(ack_code), .ack_eid(ack_eid),
		.ack_length(ack_length), .ack_hdr(ack_hdr), .ack_active(ack_active),
		.pb_target(pb_target), .pb_stage(pb_stage), .pb_shift_in(pb_shift_in),
		.pb_in_byte(pb_in_byte), .pb_commit(pb_commit), .pb_snap(pb_snap),
		.pb_shift_out(pb_shift_out), .pb_out_byte(pb_out_byte),
		.cnt_load(cnt_load), .cnt_load_value(cnt_load_value), .cnt_dec(cnt_dec),
		.cnt_zero(cnt_zero), .buf_wr(buf_wr), .frame_end(frame_end), .buf_busy(buf_busy)
	);

	byte_counter u_cnt (
		.clk(clk), .rst(rst), .load(cnt_load), .load_value(cnt_load_value),
		.dec(cnt_dec), .zero(cnt_zero)
	);

	param_bank u_bank (
		.clk(clk), .rst(rst), .target(pb_target), .stage(pb_stage),
		.shift_in(pb_shift_in), .in_byte(pb_in_byte), .commit(pb_commit),
		.snap(pb_snap), .shift_out(pb_shift_out), .gpio_read(gpio_read),
		.out_byte(pb_out_byte), .settings(settings)
	);

	ack_builder u_ack (
		.clk(clk), .rst(rst), .start(ack_start), .code(ack_code), .eid(ack_eid),
		.length(ack_length), .hdr(ack_hdr), .active(ack_active)
	);

	response_buffer u_buf (
		.clk(clk), .rst(rst), .wr(buf_wr), .frame_end(frame_end), .out(resp),
		.out_frame_valid(resp_frame_valid), .busy(buf_busy)
	);

endmodule

// File: hw/byte_counter.sv
`timescale 1ns/100ps

module byte_counter (
	input  logic       clk,
	input  logic       rst,
	input  logic       load,
	input  logic [3:0] load_value,
	input  logic       dec,
	output logic       zero
);

	logic [3:0] count;

	// Load takes priority over decrement
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= 4'd0;
		end else if (load) begin
			count <= load_value;
		end else if (dec && count != 4'd0) begin
			count <= count - 4'd1;
		end
	end

	// Loaded with N-1, so zero marks the last byte
	assign zero = (count == 4'd0);

endmodule

// File: hw/ice_cmd_pkg.sv
package ice_cmd_pkg;

	// Command bytes
	localparam logic [7:0] cmd_version = 8'h76;
	localparam logic [7:0] cmd_query_i2c = 8'h49;
	localparam logic [7:0] cmd_set_i2c = 8'h69;
	localparam logic [7:0] cmd_query_gpio = 8'h47;
	localparam logic [7:0] cmd_set_gpio = 8'h67;
	localparam logic [7:0] cmd_query_uart = 8'h55;
	localparam logic [7:0] cmd_set_uart = 8'h75;

	// Selector bytes, UART ignores its selector
	localparam logic [7:0] sel_speed = 8'h63;
	localparam logic [7:0] sel_addr = 8'h61;
	localparam logic [7:0] sel_level = 8'h6C;
	localparam logic [7:0] sel_dir = 8'h64;

	localparam logic [7:0] version_major = 8'h00;
	localparam logic [7:0] version_minor = 8'h02;

	typedef enum logic [2:0] {
		p_i2c_speed,
		p_i2c_addr,
		p_gpio_level,
		p_gpio_dir,
		p_uart_baud,
		p_none
	} param_e;

	typedef struct packed {
		logic [7:0]  i2c_speed;
		logic [15:0] i2c_addr;
		logic [23:0] gpio_level;
		logic [23:0] gpio_dir;
		logic [15:0] uart_baud;
	} settings_t;

	localparam settings_t settings_reset = '{
		i2c_speed: 8'd99,
		i2c_addr: 16'hFFFF,
		gpio_level: 24'h000000,
		gpio_dir: 24'h000000,
		uart_baud: 16'd174
	};

endpackage

// File: hw/ice_msg_pkg.sv
package ice_msg_pkg;

	// One byte of the host command bus
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       frame;
	} bus_in_t;

	// One byte of a response stream
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
	} resp_byte_t;

	localparam logic [7:0] code_ack = 8'h00;
	localparam logic [7:0] code_nak = 8'h01;

	// Longest response is six bytes
	localparam int resp_depth = 8;

endpackage

// File: hw/param_bank.sv
`timescale 1ns/100ps

module param_bank (
	input  logic                   clk,
	input  logic                   rst,
	input  ice_cmd_pkg::param_e    target,
	input  logic                   stage,
	input  logic                   shift_in,
	input  logic [7:0]             in_byte,
	input  logic                   commit,
	input  logic                   snap,
	input  logic                   shift_out,
	input  logic [23:0]            gpio_read,
	output logic [7:0]             out_byte,
	output ice_cmd_pkg::settings_t settings
);

	logic [23:0] staging;
	logic [23:0] snapshot;

	// Set bytes arrive MSB first
	always_ff @(posedge clk) begin
		if (stage) begin
			staging <= 24'h000000;
		end else if (shift_in) begin
			staging <= {staging[15:0], in_byte};
		end
	end

	// Live settings change only on commit
	always_ff @(posedge clk) begin
		if (rst) begin
			settings <= ice_cmd_pkg::settings_reset;
		end else if (commit) begin
			case (target)
				ice_cmd_pkg::p_i2c_speed: begin
					settings.i2c_speed <= staging[7:0];
				end
				ice_cmd_pkg::p_i2c_addr: begin
					settings.i2c_addr <= staging[15:0];
				end
				ice_cmd_pkg::p_gpio_level: begin
					settings.gpio_level <= staging;
				end
				ice_cmd_pkg::p_gpio_dir: begin
					settings.gpio_dir <= staging;
				end
				ice_cmd_pkg::p_uart_baud: begin
					settings.uart_baud <= staging[15:0];
				end
				default: begin
				end
			endcase
		end
	end

	// Snapshot is left aligned so the next byte is always the top one
	always_ff @(posedge clk) begin
		if (snap) begin
			case (target)
				ice_cmd_pkg::p_i2c_speed: begin
					snapshot <= {settings.i2c_speed, 16'h0000};
				end
				ice_cmd_pkg::p_i2c_addr: begin
					snapshot <= {settings.i2c_addr, 8'h00};
				end
				ice_cmd_pkg::p_gpio_level: begin
					// Level queries report the pins, not the driven level
					snapshot <= gpio_read;
				end
				ice_cmd_pkg::p_gpio_dir: begin
					snapshot <= settings.gpio_dir;
				end
				ice_cmd_pkg::p_uart_baud: begin
					snapshot <= {settings.uart_baud, 8'h00};
				end
				default: begin
					snapshot <= 24'h000000;
				end
			endcase
		end else if (shift_out) begin
			snapshot <= {snapshot[15:0], 8'h00};
		end
	end

	assign out_byte = snapshot[23:16];

endmodule

// File: hw/response_buffer.sv
`timescale 1ns/100ps

module response_buffer (
	input  logic                    clk,
	input  logic                    rst,
	input  ice_msg_pkg::resp_byte_t wr,
	input  logic                    frame_end,
	output ice_msg_pkg::resp_byte_t out,
	output logic                    out_frame_valid,
	output logic                    busy
);

	logic [7:0] mem [ice_msg_pkg::resp_depth];
	logic [$clog2(ice_msg_pkg::resp_depth)-1:0] wptr;
	logic [$clog2(ice_msg_pkg::resp_depth)-1:0] rptr;
	logic [$clog2(ice_msg_pkg::resp_depth)-1:0] last;
	logic playing;

	always_ff @(posedge clk) begin
		if (wr.valid) begin
			mem[wptr] <= wr.data;
		end
	end

	// A full buffer wraps wptr to zero, last still points at entry 7
	assign last = wptr - 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			wptr <= '0;
			rptr <= '0;
			playing <= 1'b0;
		end else if (playing) begin
			rptr <= rptr + 1'b1;
			if (rptr == last) begin
				playing <= 1'b0;
				wptr <= '0;
				rptr <= '0;
			end
		end else begin
			if (wr.valid) begin
				wptr <= wptr + 1'b1;
			end
			if (frame_end) begin
				playing <= 1'b1;
			end
		end
	end

	always_comb begin
		out.data = mem[rptr];
		out.valid = playing;
	end

	assign out_frame_valid = playing;

	// Held while a frame is being built or played out
	assign busy = playing || (wptr != '0);

endmodule

// File: test/basics_asserts.sv
`timescale 1ns/100ps

module basics_asserts (
	input logic                    clk,
	input logic                    rst,
	input ice_msg_pkg::resp_byte_t resp,
	input logic                    resp_frame_valid,
	input ice_cmd_pkg::settings_t  settings,
	input logic                    commit
);

	// A byte strobe always sits inside a response frame
	valid_in_frame: assert property (@(posedge clk) disable iff (rst)
		resp.valid |-> resp_frame_valid)
		else $error("resp.valid seen outside resp_frame_valid");

	frame_low_after_reset: assert property (@(posedge clk)
		rst |=> !resp_frame_valid)
		else $error("resp_frame_valid high after reset");

	// Live settings move only one cycle after a commit strobe
	settings_on_commit: assert property (@(posedge clk) disable iff (rst)
		!$stable(settings) |-> $past(commit))
		else $error("settings changed without a commit");

	// Playout has no gaps
	contiguous_playout: assert property (@(posedge clk) disable iff (rst)
		resp_frame_valid |-> resp.valid)
		else $error("gap in response playout");

endmodule

// File: test/basics_tb.sv
`timescale 1ns/100ps

module basics_tb;

	localparam int max_cycles = 4000;
	localparam int resp_wait = 100;
	localparam logic [7:0] own_major = 8'h00;
	localparam logic [7:0] own_minor = 8'h02;

	typedef logic [7:0] byte_q_t[$];

	logic clk;
	logic rst;
	ice_msg_pkg::bus_in_t bus;
	logic generate_nak;
	logic [23:0] gpio_read;
	ice_msg_pkg::resp_byte_t resp;
	logic resp_frame_valid;
	ice_cmd_pkg::settings_t settings;

	// Expected live settings
	ice_cmd_pkg::settings_t model;
	int seed;
	int cycles = 0;

	tb_clock u_clock (.clk(clk));

	basics_top dut (
		.clk(clk), .rst(rst), .bus(bus), .generate_nak(generate_nak),
		.gpio_read(gpio_read), .resp(resp), .resp_frame_valid(resp_frame_valid),
		.settings(settings)
	);

	bind basics_top basics_asserts u_asserts (
		.clk(clk), .rst(rst), .resp(resp), .resp_frame_valid(resp_frame_valid),
		.settings(settings), .commit(pb_commit)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "Run stopped");
	endtask

	task automatic value_error(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			abort_run($sformatf("Timeout: run still going after %0d cycles", cycles));
		end
	end

	// Idle gap first so the FSM is back in idle and frame drops between frames
	task automatic send_frame(input byte_q_t bytes);
		repeat (2) @(negedge clk);
		foreach (bytes[i]) begin
			bus.data = bytes[i];
			bus.valid = 1'b1;
			bus.frame = 1'b1;
			@(negedge clk);
		end
		bus = '0;
	endtask

	task automatic get_frame(output byte_q_t got);
		int waited;
		waited = 0;
		got = {};
		while (!resp_frame_valid) begin
			if (waited >= resp_wait) begin
				abort_run("No response frame arrived within the wait limit");
			end
			@(negedge clk);
			waited++;
		end
		while (resp_frame_valid) begin
			if (resp.valid) begin
				got.push_back(resp.data);
			end
			@(negedge clk);
		end
	endtask

	task automatic compare_frame(input string what, input byte_q_t exp, input byte_q_t got);
		assert (got.size() == exp.size()) else
			value_error({what, " length"}, got.size(), exp.size());
		foreach (exp[i]) begin
			assert (got[i] == exp[i]) else
				value_error($sformatf("%s byte %0d", what, i), got[i], exp[i]);
		end
	endtask

	// Code, EID, count, then n value bytes MSB first
	function automatic byte_q_t expect_reply(input logic [7:0] code, input logic [7:0] eid,
		input int n, input logic [23:0] value);
		byte_q_t q;
		q.push_back(code);
		q.push_back(eid);
		q.push_back(8'(n));
		for (int i = n - 1; i >= 0; i--) begin
			q.push_back(value[i*8 +: 8]);
		end
		return q;
	endfunction

	task automatic query_param(input logic [7:0] cmd, input logic [7:0] sel, input int n,
		input logic [23:0] value, input string what);
		byte_q_t frame;
		byte_q_t got;
		logic [7:0] eid;
		eid = 8'($random(seed));
		frame = {};
		frame.push_back(cmd);
		frame.push_back(eid);
		frame.push_back(8'h01);
		frame.push_back(sel);
		send_frame(frame);
		get_frame(got);
		compare_frame(what, expect_reply(8'h00, eid, n, value), got);
	endtask

	task automatic set_param(input logic [7:0] cmd, input logic [7:0] sel, input int n,
		input logic [23:0] value, input string what);
		byte_q_t frame;
		byte_q_t got;
		logic [7:0] eid;
		eid = 8'($random(seed));
		frame = {};
		frame.push_back(cmd);
		frame.push_back(eid);
		frame.push_back(8'(n + 1));
		frame.push_back(sel);
		for (int i = n - 1; i >= 0; i--) begin
			frame.push_back(value[i*8 +: 8]);
		end
		send_frame(frame);
		get_frame(got);
		compare_frame(what, expect_reply(8'h00, eid, 0, 24'h0), got);
	endtask

	task automatic check_settings();
		assert (settings == model) else
			value_error("settings", settings, model);
	endtask

	task automatic reset_queries();
		check_settings();
		query_param(ice_cmd_pkg::cmd_query_i2c, 8'h63, 1, 24'd99, "reset i2c speed");
		query_param(ice_cmd_pkg::cmd_query_i2c, 8'h61, 2, 24'h00FFFF, "reset i2c addr");
		query_param(ice_cmd_pkg::cmd_query_gpio, 8'h6C, 3, gpio_read, "reset gpio level");
		query_param(ice_cmd_pkg::cmd_query_gpio, 8'h64, 3, 24'h000000, "reset gpio dir");
		query_param(ice_cmd_pkg::cmd_query_uart, 8'h62, 2, 24'd174, "reset uart baud");
	endtask

	task automatic version_case(input logic [7:0] major, input logic [7:0] minor);
		byte_q_t frame;
		byte_q_t got;
		logic [7:0] eid;
		eid = 8'($random(seed));
		frame = {};
		frame.push_back(ice_cmd_pkg::cmd_version);
		frame.push_back(eid);
		frame.push_back(8'h02);
		frame.push_back(major);
		frame.push_back(minor);
		send_frame(frame);
		get_frame(got);
		if (major == own_major && minor == own_minor) begin
			compare_frame("version ack", expect_reply(8'h00, eid, 0, 24'h0), got);
		end else begin
			compare_frame("version nak",
				expect_reply(8'h01, eid, 2, {8'h00, own_major, own_minor}), got);
		end
	endtask

	task automatic version_requests();
		version_case(8'h00, 8'h02);
		version_case(8'h00, 8'h01);
		version_case(8'h01, 8'h02);
		version_case(8'h02, 8'h00);
	endtask

	task automatic set_then_query();
		logic [31:0] r;
		r = $random(seed);
		model.i2c_speed = r[7:0];
		set_param(ice_cmd_pkg::cmd_set_i2c, 8'h63, 1, {16'h0, r[7:0]}, "set i2c speed");
		check_settings();
		query_param(ice_cmd_pkg::cmd_query_i2c, 8'h63, 1, {16'h0, r[7:0]}, "i2c speed");
		r = $random(seed);
		model.i2c_addr = r[15:0];
		set_param(ice_cmd_pkg::cmd_set_i2c, 8'h61, 2, {8'h0, r[15:0]}, "set i2c addr");
		check_settings();
		query_param(ice_cmd_pkg::cmd_query_i2c, 8'h61, 2, {8'h0, r[15:0]}, "i2c addr");
		r = $random(seed);
		model.gpio_level = r[23:0];
		set_param(ice_cmd_pkg::cmd_set_gpio, 8'h6C, 3, r[23:0], "set gpio level");
		check_settings();
		r = $random(seed);
		model.gpio_dir = r[23:0];
		set_param(ice_cmd_pkg::cmd_set_gpio, 8'h64, 3, r[23:0], "set gpio dir");
		check_settings();
		query_param(ice_cmd_pkg::cmd_query_gpio, 8'h64, 3, r[23:0], "gpio dir");
		r = $random(seed);
		model.uart_baud = r[15:0];
		set_param(ice_cmd_pkg::cmd_set_uart, 8'h62, 2, {8'h0, r[15:0]}, "set uart baud");
		check_settings();
		query_param(ice_cmd_pkg::cmd_query_uart, 8'h62, 2, {8'h0, r[15:0]}, "uart baud");
	endtask

	// Level query must see the pins, never the stored level
	task automatic gpio_pin_query();
		logic [31:0] r;
		r = $random(seed);
		gpio_read = r[23:0];
		if (gpio_read == model.gpio_level) begin
			gpio_read = ~gpio_read;
		end
		query_param(ice_cmd_pkg::cmd_query_gpio, 8'h6C, 3, gpio_read, "gpio pins");
		check_settings();
	endtask

	task automatic rejected_requests();
		byte_q_t frame;
		byte_q_t got;
		logic [7:0] eid;
		eid = 8'($random(seed));
		frame = {};
		frame.push_back(ice_cmd_pkg::cmd_query_i2c);
		frame.push_back(eid);
		frame.push_back(8'h01);
		frame.push_back(8'h7A);
		send_frame(frame);
		get_frame(got);
		compare_frame("bad selector", expect_reply(8'h01, eid, 0, 24'h0), got);
		// Unknown command byte, no answer expected
		frame = {};
		frame.push_back(8'h33);
		frame.push_back(eid);
		frame.push_back(8'h01);
		frame.push_back(8'h63);
		send_frame(frame);
		repeat (50) begin
			assert (!resp_frame_valid) else
				abort_run("A response frame followed an unknown command byte");
			@(negedge clk);
		end
		check_settings();
		generate_nak = 1'b1;
		@(negedge clk);
		generate_nak = 1'b0;
		get_frame(got);
		compare_frame("generate nak", expect_reply(8'h01, 8'h00, 0, 24'h0), got);
	endtask

	initial begin
		seed = 37482;
		rst = 1'b1;
		bus = '0;
		generate_nak = 1'b0;
		gpio_read = 24'h000000;
		model.i2c_speed = 8'd99;
		model.i2c_addr = 16'hFFFF;
		model.gpio_level = 24'h000000;
		model.gpio_dir = 24'h000000;
		model.uart_baud = 16'd174;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		reset_queries();
		version_requests();
		set_then_query();
		gpio_pin_query();
		rejected_requests();
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	// Half of the 20 ns period
	localparam int half_period = 10;

	initial begin
		clk = 1'b0;
		forever begin
			#half_period clk = ~clk;
		end
	end

endmodule
